// ==== src/sys_pkg.sv ====
//////////////////////////////
// Execute slice shared types
// Data widths, register index, ALU operation codes
// and the packet that travels from dispatch to the ALU
//////////////////////////////

package sys_pkg;

    // Datapath width in bits
    localparam int data_w = 32;

    // Architectural register count
    localparam int reg_count = 32;

    // Default issue queue depth
    localparam int queue_depth = 4;

    // Register index, wide enough for reg_count entries
    typedef logic [4:0] reg_idx_t;

    // One data word
    typedef logic [data_w-1:0] data_t;

    // Register 0 is hard-wired to zero
    localparam reg_idx_t zero_reg = 5'd0;

    // ALU operation codes
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_xor  = 3'd3,
        op_pass = 3'd4
    } alu_op_t;

    // Issue packet, 3 + 5 + 32 + 32 = 72 bits
    typedef struct packed {
        alu_op_t  op;
        reg_idx_t dest;
        data_t    opa;
        data_t    opb;
    } issue_pkt_t;

endpackage

// ==== src/exec_if.sv ====
//////////////////////////////
// Issue packet link
// Four-phase req/ack handshake carrying one issue packet
//////////////////////////////

`timescale 1ns/1ps

interface exec_if;

    // Request from the sender, held until ack rises
    logic req;

    // Acknowledge from the receiver, dropped after req falls
    logic ack;

    // Payload, stable while req is high
    sys_pkg::issue_pkt_t pkt;

    // Upstream side drives req and payload
    modport sender (
        output req,
        output pkt,
        input  ack
    );

    // Downstream side answers with ack
    modport receiver (
        input  req,
        input  pkt,
        output ack
    );

endinterface

// ==== src/mem_dp.sv ====
//////////////////////////////
// Multi-port memory
// Several combinational read ports, one write port
// Same-cycle write data is forwarded to matching reads
//////////////////////////////

`timescale 1ns/1ps

module mem_dp #(
    parameter int width      = 32,
    parameter int depth      = 32,
    parameter int read_ports = 2
) (
    input  logic                                     clock,
    input  logic [read_ports-1:0]                    re,
    input  logic [read_ports-1:0][$clog2(depth)-1:0] raddr,
    input  logic                                     we,
    input  logic [$clog2(depth)-1:0]                 waddr,
    input  logic [width-1:0]                         wdata,
    output logic [read_ports-1:0][width-1:0]         rdata
);

    // Storage array, contents undefined until written
    logic [width-1:0] mem [depth];

    //////////////////////////////
    // Write port
    //////////////////////////////

    // Single write on the rising edge
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < read_ports; i++) begin
            if (!re[i]) begin
                // Idle port outputs zero
                rdata[i] = '0;
            end else if (we && (waddr == raddr[i])) begin
                // Forward the word being written this cycle
                rdata[i] = wdata;
            end else begin
                rdata[i] = mem[raddr[i]];
            end
        end
    end

endmodule

// ==== src/regfile.sv ====
//////////////////////////////
// Register file
// Two read ports, one write port, register 0 reads zero
// No reset on the storage
//////////////////////////////

`timescale 1ns/1ps

module regfile #(
    parameter int depth = 32
) (
    input  logic             clock,
    input  sys_pkg::reg_idx_t read_idx_1,
    input  sys_pkg::reg_idx_t read_idx_2,
    input  logic             write_en,
    input  sys_pkg::reg_idx_t write_idx,
    input  sys_pkg::data_t    write_data,
    output sys_pkg::data_t    read_out_1,
    output sys_pkg::data_t    read_out_2
);

    localparam int addr_w = $clog2(depth);

    // Read enables, low for register 0
    logic [1:0]             rd_en;
    // Packed read addresses, port 0 serves read_idx_1
    logic [1:0][addr_w-1:0] rd_addr;
    // Raw memory outputs before the zero override
    logic [1:0][sys_pkg::data_w-1:0] rd_data;
    // Write enable after blocking register 0
    logic                   wr_en;

    assign rd_en[0]   = (read_idx_1 != sys_pkg::zero_reg);
    assign rd_en[1]   = (read_idx_2 != sys_pkg::zero_reg);
    assign rd_addr[0] = read_idx_1[addr_w-1:0];
    assign rd_addr[1] = read_idx_2[addr_w-1:0];

    // Writes to register 0 are dropped
    assign wr_en = write_en && (write_idx != sys_pkg::zero_reg);

    mem_dp #(
        .width     (sys_pkg::data_w),
        .depth     (depth),
        .read_ports(2)
    ) reg_mem (
        .clock(clock),
        .re   (rd_en),
        .raddr(rd_addr),
        .we   (wr_en),
        .waddr(write_idx[addr_w-1:0]),
        .wdata(write_data),
        .rdata(rd_data)
    );

    // Register 0 always returns zero
    assign read_out_1 = rd_en[0] ? rd_data[0] : '0;
    assign read_out_2 = rd_en[1] ? rd_data[1] : '0;

endmodule

// ==== src/dispatch_unit.sv ====
//////////////////////////////
// Dispatch stage
// Takes one instruction over a four-phase handshake,
// stalls on RAW and WAW hazards through a busy table,
// reads operands and hands a packet to the issue queue
//////////////////////////////

`timescale 1ns/1ps

module dispatch_unit (
    input  logic              clock,
    input  logic              rst_n,
    // Instruction port
    input  logic              instr_req,
    input  sys_pkg::alu_op_t  instr_op,
    input  sys_pkg::reg_idx_t instr_dest,
    input  sys_pkg::reg_idx_t instr_src1,
    input  sys_pkg::reg_idx_t instr_src2,
    input  logic              instr_use_imm,
    input  sys_pkg::data_t    instr_imm,
    output logic              instr_ack,
    // Register file read side
    output sys_pkg::reg_idx_t read_idx_1,
    output sys_pkg::reg_idx_t read_idx_2,
    input  sys_pkg::data_t    read_out_1,
    input  sys_pkg::data_t    read_out_2,
    // Writeback clears busy marks
    input  logic              wb_valid,
    input  sys_pkg::reg_idx_t wb_idx,
    // Packet towards the queue
    exec_if.sender            iss
);

    // One pending-write flag per register
    logic [sys_pkg::reg_count-1:0] busy;
    // Bits cleared by this cycle's writeback
    logic [sys_pkg::reg_count-1:0] clr_vec;
    // Bit set by this cycle's dispatch
    logic [sys_pkg::reg_count-1:0] set_vec;
    // Busy view with the current writeback already applied
    logic [sys_pkg::reg_count-1:0] busy_eff;
    logic                          hazard;
    logic                          accept;

    //////////////////////////////
    // Hazard check
    //////////////////////////////

    always_comb begin
        clr_vec = '0;
        if (wb_valid) begin
            clr_vec[wb_idx] = 1'b1;
        end
    end

    assign busy_eff = busy & ~clr_vec;

    // src2 only matters when the immediate is not used
    assign hazard = busy_eff[instr_src1]
                 || (!instr_use_imm && busy_eff[instr_src2])
                 || busy_eff[instr_dest];

    // Both handshakes must be back at rest before a new instruction
    assign accept = instr_req && !instr_ack && !iss.req && !iss.ack && !hazard;

    always_comb begin
        set_vec = '0;
        // Register 0 never becomes busy
        if (accept && (instr_dest != sys_pkg::zero_reg)) begin
            set_vec[instr_dest] = 1'b1;
        end
    end

    // Operand read straight from the instruction fields
    assign read_idx_1 = instr_src1;
    assign read_idx_2 = instr_src2;

    //////////////////////////////
    // Control state
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= '0;
            instr_ack <= 1'b0;
            iss.req   <= 1'b0;
        end else begin
            // Set wins over clear for a reused destination
            busy <= busy_eff | set_vec;
            if (accept) begin
                instr_ack <= 1'b1;
            end else if (instr_ack && !instr_req) begin
                instr_ack <= 1'b0;
            end
            if (accept) begin
                iss.req <= 1'b1;
            end else if (iss.req && iss.ack) begin
                iss.req <= 1'b0;
            end
        end
    end

    // Packet captured on accept, held while req is up
    always_ff @(posedge clock) begin
        if (accept) begin
            iss.pkt.op   <= instr_op;
            iss.pkt.dest <= instr_dest;
            iss.pkt.opa  <= read_out_1;
            iss.pkt.opb  <= instr_use_imm ? instr_imm : read_out_2;
        end
    end

endmodule

// ==== src/issue_queue.sv ====
//////////////////////////////
// Issue queue
// Circular FIFO of issue packets in program order,
// four-phase handshake on both the enqueue and dequeue side
//////////////////////////////

`timescale 1ns/1ps

module issue_queue #(
    parameter int depth = 4
) (
    input  logic     clock,
    input  logic     rst_n,
    exec_if.receiver enq,
    exec_if.sender   deq
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // Packet storage, no reset needed
    sys_pkg::issue_pkt_t slots [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == cnt_w'(depth));

    // Take a new packet only when there is room
    assign push = enq.req && !enq.ack && !full;

    // Entry leaves when the ALU acknowledges it
    assign pop = deq.req && deq.ack;

    // Head entry drives the output, rd_ptr is frozen while req is up
    assign deq.pkt = slots[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= enq.pkt;
        end
    end

    //////////////////////////////
    // Pointers and handshakes
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            enq.ack <= 1'b0;
            deq.req <= 1'b0;
        end else begin
            // Enqueue side
            if (push) begin
                enq.ack <= 1'b1;
                wr_ptr  <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (enq.ack && !enq.req) begin
                enq.ack <= 1'b0;
            end
            // Dequeue side, next req waits for the old ack to drop
            if (pop) begin
                deq.req <= 1'b0;
                rd_ptr  <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end else if (!deq.req && !deq.ack && (count != '0)) begin
                deq.req <= 1'b1;
            end
            // Occupancy
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== src/alu_wb.sv ====
//////////////////////////////
// ALU and writeback
// Executes one packet per handshake and pulses the
// register file write port for a single cycle
//////////////////////////////

`timescale 1ns/1ps

module alu_wb (
    input  logic              clock,
    input  logic              rst_n,
    exec_if.receiver          iss,
    output logic              wb_valid,
    output sys_pkg::reg_idx_t wb_idx,
    output sys_pkg::data_t    wb_data
);

    sys_pkg::data_t result;
    // New packet seen, ack not yet given
    logic           take;

    assign take = iss.req && !iss.ack;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    always_comb begin
        case (iss.pkt.op)
            sys_pkg::op_add:  result = iss.pkt.opa + iss.pkt.opb;
            sys_pkg::op_sub:  result = iss.pkt.opa - iss.pkt.opb;
            sys_pkg::op_and:  result = iss.pkt.opa & iss.pkt.opb;
            sys_pkg::op_xor:  result = iss.pkt.opa ^ iss.pkt.opb;
            sys_pkg::op_pass: result = iss.pkt.opb;
            // Unused encodings yield zero
            default:          result = '0;
        endcase
    end

    // Writeback payload, only meaningful with wb_valid
    always_ff @(posedge clock) begin
        if (take) begin
            wb_idx  <= iss.pkt.dest;
            wb_data <= result;
        end
    end

    //////////////////////////////
    // Handshake and pulse
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            iss.ack  <= 1'b0;
        end else begin
            // Single-cycle pulse per accepted packet
            wb_valid <= take;
            if (take) begin
                iss.ack <= 1'b1;
            end else if (iss.ack && !iss.req) begin
                iss.ack <= 1'b0;
            end
        end
    end

endmodule

// ==== src/exec_top.sv ====
//////////////////////////////
// Execute slice top level
// Dispatch, issue queue, ALU and register file
// behind plain instruction and writeback ports
//////////////////////////////

`timescale 1ns/1ps

module exec_top #(
    parameter int queue_depth = sys_pkg::queue_depth
) (
    input  logic              clock,
    input  logic              rst_n,
    // Instruction handshake
    input  logic              instr_req,
    input  sys_pkg::alu_op_t  instr_op,
    input  sys_pkg::reg_idx_t instr_dest,
    input  sys_pkg::reg_idx_t instr_src1,
    input  sys_pkg::reg_idx_t instr_src2,
    input  logic              instr_use_imm,
    input  sys_pkg::data_t    instr_imm,
    output logic              instr_ack,
    // Writeback observation
    output logic              wb_valid,
    output sys_pkg::reg_idx_t wb_idx,
    output sys_pkg::data_t    wb_data
);

    sys_pkg::reg_idx_t read_idx_1;
    sys_pkg::reg_idx_t read_idx_2;
    sys_pkg::data_t    read_out_1;
    sys_pkg::data_t    read_out_2;

    // Dispatch to queue, queue to ALU
    exec_if disp_q ();
    exec_if q_alu ();

    dispatch_unit u_dispatch (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr_op     (instr_op),
        .instr_dest   (instr_dest),
        .instr_src1   (instr_src1),
        .instr_src2   (instr_src2),
        .instr_use_imm(instr_use_imm),
        .instr_imm    (instr_imm),
        .instr_ack    (instr_ack),
        .read_idx_1   (read_idx_1),
        .read_idx_2   (read_idx_2),
        .read_out_1   (read_out_1),
        .read_out_2   (read_out_2),
        .wb_valid     (wb_valid),
        .wb_idx       (wb_idx),
        .iss          (disp_q.sender)
    );

    issue_queue #(
        .depth(queue_depth)
    ) u_queue (
        .clock(clock),
        .rst_n(rst_n),
        .enq  (disp_q.receiver),
        .deq  (q_alu.sender)
    );

    alu_wb u_alu (
        .clock   (clock),
        .rst_n   (rst_n),
        .iss     (q_alu.receiver),
        .wb_valid(wb_valid),
        .wb_idx  (wb_idx),
        .wb_data (wb_data)
    );

    // Writeback also feeds the register file write port
    regfile #(
        .depth(sys_pkg::reg_count)
    ) u_regfile (
        .clock     (clock),
        .read_idx_1(read_idx_1),
        .read_idx_2(read_idx_2),
        .write_en  (wb_valid),
        .write_idx (wb_idx),
        .write_data(wb_data),
        .read_out_1(read_out_1),
        .read_out_2(read_out_2)
    );

endmodule

// ==== testbench/exec_props.sv ====
//////////////////////////////
// Execute slice properties
// Instruction handshake order and writeback pulse width
//////////////////////////////

`timescale 1ns/1ps

module exec_props (
    input logic clock,
    input logic rst_n,
    input logic instr_req,
    input logic instr_ack,
    input logic wb_valid
);

    // Number of property failures so far
    int fail_count;

    // Ack answers a request that was up on the previous edge
    ack_rise_needs_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(instr_ack) |-> $past(instr_req)
    ) else begin
        $error("instr_ack rose with no instr_req pending");
        fail_count++;
    end

    // Writeback is a single-cycle pulse
    wb_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        wb_valid |=> !wb_valid
    ) else begin
        $error("wb_valid held high for two cycles");
        fail_count++;
    end

    // Ack drops only once the request is gone
    ack_fall_after_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(instr_ack) |-> !$past(instr_req)
    ) else begin
        $error("instr_ack fell while instr_req was still high");
        fail_count++;
    end

endmodule

// Attach to every execute slice top level
bind exec_top exec_props u_props (
    .clock    (clock),
    .rst_n    (rst_n),
    .instr_req(instr_req),
    .instr_ack(instr_ack),
    .wb_valid (wb_valid)
);

// ==== testbench/exec_tb.sv ====
//////////////////////////////
// Execute slice testbench
// Vector-driven instruction stream over the four-phase port,
// in-order writeback checks, reset checks and a watchdog
//////////////////////////////

`timescale 1ns/1ps

module exec_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int max_vectors  = 64;
    // test, op, dest, src1, src2, use_imm, imm, expected
    localparam int vec_fields   = 8;

    logic              clock;
    logic              rst_n;
    logic              instr_req;
    sys_pkg::alu_op_t  instr_op;
    sys_pkg::reg_idx_t instr_dest;
    sys_pkg::reg_idx_t instr_src1;
    sys_pkg::reg_idx_t instr_src2;
    logic              instr_use_imm;
    sys_pkg::data_t    instr_imm;
    logic              instr_ack;
    logic              wb_valid;
    sys_pkg::reg_idx_t wb_idx;
    sys_pkg::data_t    wb_data;

    // Flat vector table, one row per vec_fields words
    logic [31:0] vec_mem [max_vectors*vec_fields];
    int          n_vec;
    int          check_idx;
    int          check_count;
    int          error_count;
    int          test_count;
    int          test_checks;
    int          test_errors;
    logic [31:0] lcg_state;
    logic        loaded;

    exec_top #(
        .queue_depth(sys_pkg::queue_depth)
    ) UUT (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr_op     (instr_op),
        .instr_dest   (instr_dest),
        .instr_src1   (instr_src1),
        .instr_src2   (instr_src2),
        .instr_use_imm(instr_use_imm),
        .instr_imm    (instr_imm),
        .instr_ack    (instr_ack),
        .wb_valid     (wb_valid),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] vec_field(input int idx, input int col);
        return vec_mem[idx*vec_fields + col];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        assert (actual === expected) else begin
            $display("error %s expected %h got %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // One report line per finished test, counters restart
    task automatic finish_test(input int num);
        $display("test %0d finished: %0d checks, %0d errors", num, test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Four-phase cycle, called on a falling edge
    task automatic drive_instr(input int idx);
        instr_op      = sys_pkg::alu_op_t'(3'(vec_field(idx, 1)));
        instr_dest    = 5'(vec_field(idx, 2));
        instr_src1    = 5'(vec_field(idx, 3));
        instr_src2    = 5'(vec_field(idx, 4));
        instr_use_imm = (vec_field(idx, 5) != 0);
        instr_imm     = vec_field(idx, 6);
        instr_req     = 1'b1;
        @(negedge clock);
        while (!instr_ack) @(negedge clock);
        instr_req = 1'b0;
        @(negedge clock);
        while (instr_ack) @(negedge clock);
    endtask

    //////////////////////////////
    // Stimulus and reset test
    //////////////////////////////

    initial begin
        int gap;
        rst_n         = 1'b0;
        instr_req     = 1'b0;
        instr_op      = sys_pkg::op_add;
        instr_dest    = '0;
        instr_src1    = '0;
        instr_src2    = '0;
        instr_use_imm = 1'b0;
        instr_imm     = '0;
        check_idx     = 0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        test_checks   = 0;
        test_errors   = 0;
        lcg_state     = 32'hb55a;
        loaded        = 1'b0;
        $readmemh("testbench/exec_vectors.txt", vec_mem);
        // Rows end at the first unwritten test number
        n_vec = 0;
        while (n_vec < max_vectors && !$isunknown(vec_mem[n_vec*vec_fields])) n_vec++;
        loaded = 1'b1;
        // Test 1, outputs quiet through reset and just after
        repeat (reset_cycles) begin
            @(negedge clock);
            check_value("instr_ack", 32'h0, 32'(instr_ack));
            check_value("wb_valid", 32'h0, 32'(wb_valid));
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clock);
            check_value("instr_ack", 32'h0, 32'(instr_ack));
            check_value("wb_valid", 32'h0, 32'(wb_valid));
        end
        finish_test(1);
        for (int i = 0; i < n_vec; i++) begin
            drive_instr(i);
            lcg_state = lcg_next(lcg_state);
            // Burst test runs with no idle gaps
            gap = (vec_field(i, 0) == 6) ? 0 : int'(lcg_state[17:16]);
            repeat (gap) @(negedge clock);
        end
        wait (check_idx == n_vec);
        // Room for any stray writeback
        repeat (8) @(negedge clock);
        // Handshake and pulse property failures count as errors
        error_count += UUT.u_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    //////////////////////////////
    // Writeback monitor
    //////////////////////////////

    initial begin
        wait (loaded);
        forever begin
            @(negedge clock);
            if (rst_n && wb_valid) begin
                assert (check_idx < n_vec) else begin
                    $display("writeback to register %0d came after the last instruction",
                             wb_idx);
                    error_count++;
                end
                if (check_idx < n_vec) begin
                    // In-order match against the next expected row
                    check_value("wb_idx", vec_field(check_idx, 2), 32'(wb_idx));
                    check_value("wb_data", vec_field(check_idx, 7), wb_data);
                    if (check_idx == n_vec - 1
                        || vec_field(check_idx + 1, 0) != vec_field(check_idx, 0)) begin
                        finish_test(int'(vec_field(check_idx, 0)));
                    end
                    check_idx++;
                end
            end
        end
    end

    // Watchdog, 64 cycles per instruction
    initial begin
        wait (loaded);
        @(posedge rst_n);
        #(n_vec * 64 * clk_period);
        $display("timeout: only %0d of %0d writebacks arrived", check_idx, n_vec);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== compile.f ====
src/sys_pkg.sv
src/exec_if.sv
src/mem_dp.sv
src/regfile.sv
src/dispatch_unit.sv
src/issue_queue.sv
src/alu_wb.sv
src/exec_top.sv
testbench/exec_props.sv
testbench/exec_tb.sv

// ==== testbench/exec_vectors.txt ====
// test op dest src1 src2 use_imm imm expected_wb_data, all hex
// op: 0 add, 1 sub, 2 and, 3 xor, 4 pass
2 4 01 00 00 1 00000005 00000005
2 4 02 00 00 1 00000003 00000003
2 4 03 00 00 1 f0f000ff f0f000ff
2 4 04 00 00 1 12345678 12345678
3 0 05 01 02 0 00000000 00000008
3 1 06 02 01 0 00000000 fffffffe
3 2 07 03 04 0 00000000 10300078
3 3 08 03 04 0 00000000 e2c45687
3 0 09 04 00 1 00000010 12345688
4 0 0a 01 01 0 00000000 0000000a
4 0 0a 0a 02 0 00000000 0000000d
4 1 0b 0a 01 0 00000000 00000008
4 3 0c 0b 0a 0 00000000 00000005
5 4 00 00 00 1 deadbeef deadbeef
5 0 0d 00 00 0 00000000 00000000
5 0 0e 00 02 0 00000000 00000003
5 1 16 02 00 0 00000000 00000003
6 4 0f 00 00 1 00000001 00000001
6 4 10 00 00 1 00000002 00000002
6 0 11 01 02 0 00000000 00000008
6 2 12 03 03 0 00000000 f0f000ff
6 3 13 04 04 0 00000000 00000000
6 1 14 00 01 0 00000000 fffffffb
6 4 15 00 00 1 a5a5a5a5 a5a5a5a5
6 0 17 05 06 0 00000000 00000006
